//--- src/dev_entropy_pkg.sv
/*
 * Device entropy shared constants
 * Word, rate and counter widths plus the fast-start length
 */
`default_nettype none

package dev_entropy_pkg;

  // Source word
  localparam int WordW   = 32;               // Bits per entropy word
  localparam int BitIdxW = $clog2(WordW);    // Bit index inside a word

  // Rate setting, interval is 2**setting cycles
  localparam int RateW = 4;

  // Pacer countdown, max reload 2**15 - 1
  localparam int CntW = 16;

  // Fast start after reset
  localparam int FastStartBits = 64;         // Bits at one per cycle
  localparam int FastCntW      = $clog2(FastStartBits + 1);  // Counts 0..64

endpackage : dev_entropy_pkg

`default_nettype wire

//--- src/sync_2ff.sv
/*
 * Two-flop synchronizer
 * Brings an asynchronous control bus into clk_dev_i, resets to zero
 */
`timescale 1ns/10ps
`default_nettype none

module sync_2ff #(
  parameter int Width = 1
) (
  input  logic             clk_dev_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,        // Asynchronous input
  output logic [Width-1:0] q_o         // Synchronized output
);

  logic [Width-1:0] meta_q;            // First stage, may go metastable

  always_ff @(posedge clk_dev_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_q <= '0;
      q_o    <= '0;
    end else begin
      meta_q <= d_i;
      q_o    <= meta_q;                // Second stage settles
    end
  end

endmodule : sync_2ff

`default_nettype wire

//--- src/entropy_word_rx.sv
/*
 * Entropy word receiver
 * Four-phase req/ack slave toward the source, valid/ready toward the packer
 */
`timescale 1ns/10ps
`default_nettype none

module entropy_word_rx (
  input  logic                              clk_dev_i,
  input  logic                              rst_ni,
  // Source side, four-phase
  input  logic                              src_req_i,
  input  logic [dev_entropy_pkg::WordW-1:0] src_data_i,   // Stable while req high
  output logic                              src_ack_o,
  // Packer side, valid/ready
  output logic                              word_valid_o,
  output logic [dev_entropy_pkg::WordW-1:0] word_data_o,
  input  logic                              word_ready_i
);

  import dev_entropy_pkg::*;

  logic             req_sync;        // Request in clk_dev_i
  logic             ack_q;           // Acknowledge state
  logic             valid_q;         // Holding register full
  logic [WordW-1:0] data_q;          // Holding register
  logic             capture;
  logic             release_ack;
  logic             handoff;

  //////////////////////////////////////////////////////////////////////
  // Request synchronizer
  //////////////////////////////////////////////////////////////////////
  sync_2ff #(
    .Width (1)
  ) u_req_sync (
    .clk_dev_i (clk_dev_i),
    .rst_ni    (rst_ni),
    .d_i       (src_req_i),
    .q_o       (req_sync)
  );

  //////////////////////////////////////////////////////////////////////
  // Handshake control
  //////////////////////////////////////////////////////////////////////

  // New word only when the previous one has left the holding register
  assign capture     = req_sync && !ack_q && !valid_q;
  assign release_ack = ack_q && !req_sync;              // Phase 4
  assign handoff     = valid_q && word_ready_i;         // Packer takes it

  always_ff @(posedge clk_dev_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (capture) begin
      ack_q <= 1'b1;
    end else if (release_ack) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_dev_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;                 // Never set and cleared together
    end else if (handoff) begin
      valid_q <= 1'b0;
    end
  end

  // Payload, source holds it steady until ack
  always_ff @(posedge clk_dev_i) begin
    if (capture) begin
      data_q <= src_data_i;
    end
  end

  assign src_ack_o    = ack_q;
  assign word_valid_o = valid_q;
  assign word_data_o  = data_q;      // Frozen while valid and not ready

endmodule : entropy_word_rx

`default_nettype wire

//--- src/bit_packer.sv
/*
 * Bit packer
 * Two-word store feeding a 32-to-1 shifter, one bit per take, LSB first
 */
`timescale 1ns/10ps
`default_nettype none

module bit_packer (
  input  logic                              clk_dev_i,
  input  logic                              rst_ni,
  // Word input, valid/ready
  input  logic                              word_valid_i,
  input  logic [dev_entropy_pkg::WordW-1:0] word_data_i,
  output logic                              word_ready_o,
  // Bit output toward the pacer
  output logic                              bit_avail_o,
  output logic                              bit_data_o,
  input  logic                              bit_take_i
);

  import dev_entropy_pkg::*;

  logic [WordW-1:0]   shift_q;       // Active word, bit 0 is next out
  logic [BitIdxW-1:0] idx_q;         // Bits already taken from shift_q
  logic               shift_vld_q;
  logic [WordW-1:0]   buf_q;         // Second slot
  logic               buf_vld_q;
  logic               accept;
  logic               last_bit;
  logic               shift_free;

  assign accept     = word_valid_i && word_ready_o;
  assign last_bit   = bit_take_i && (idx_q == '1);    // Bit 31 leaves now
  assign shift_free = !shift_vld_q || last_bit;       // Shifter can reload

  //////////////////////////////////////////////////////////////////////
  // Shifter control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_dev_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_vld_q <= 1'b0;
      idx_q       <= '0;
    end else if (shift_free) begin
      shift_vld_q <= buf_vld_q || accept;   // Older word wins
      idx_q       <= '0;
    end else if (bit_take_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_dev_i) begin
    if (shift_free) begin
      if (buf_vld_q) begin
        shift_q <= buf_q;
      end else if (accept) begin
        shift_q <= word_data_i;              // Straight in when idle
      end
    end else if (bit_take_i) begin
      shift_q <= shift_q >> 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Second slot
  //////////////////////////////////////////////////////////////////////

  // accept implies the slot is empty
  always_ff @(posedge clk_dev_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_vld_q <= 1'b0;
    end else if (accept && !shift_free) begin
      buf_vld_q <= 1'b1;                     // Park behind the shifter
    end else if (shift_free && buf_vld_q) begin
      buf_vld_q <= 1'b0;                     // Moved into the shifter
    end
  end

  always_ff @(posedge clk_dev_i) begin
    if (accept && !shift_free) begin
      buf_q <= word_data_i;
    end
  end

  assign word_ready_o = !buf_vld_q;
  assign bit_avail_o  = shift_vld_q;
  assign bit_data_o   = shift_q[0];

endmodule : bit_packer

`default_nettype wire

//--- src/rate_pacer.sv
/*
 * Rate pacer
 * Fast start, then one bit strobe every 2**rate cycles while enabled
 */
`timescale 1ns/10ps
`default_nettype none

module rate_pacer (
  input  logic                              clk_dev_i,
  input  logic                              rst_ni,
  input  logic                              dev_en_i,     // Asynchronous
  input  logic [dev_entropy_pkg::RateW-1:0] dev_rate_i,   // Asynchronous
  input  logic                              bit_avail_i,
  input  logic                              bit_data_i,
  output logic                              bit_take_o,
  output logic                              dev_bit_o,
  output logic                              dev_bit_valid_o
);

  import dev_entropy_pkg::*;

  logic                en_sync;
  logic [RateW-1:0]    rate_sync;
  logic [FastCntW-1:0] fast_cnt_q;     // Bits taken during fast start
  logic                fast_start;
  logic                fast_last;
  logic [CntW-1:0]     reload;
  logic [CntW-1:0]     cnt_q;
  logic                pulse;

  sync_2ff #(.Width(1)) u_en_sync (
    .clk_dev_i (clk_dev_i),
    .rst_ni    (rst_ni),
    .d_i       (dev_en_i),
    .q_o       (en_sync)
  );

  sync_2ff #(.Width(RateW)) u_rate_sync (
    .clk_dev_i (clk_dev_i),
    .rst_ni    (rst_ni),
    .d_i       (dev_rate_i),
    .q_o       (rate_sync)
  );

  //////////////////////////////////////////////////////////////////////
  // Fast start and countdown
  //////////////////////////////////////////////////////////////////////
  assign fast_start = (fast_cnt_q != FastCntW'(FastStartBits));
  assign fast_last  = bit_take_o && (fast_cnt_q == FastCntW'(FastStartBits - 1));

  always_ff @(posedge clk_dev_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fast_cnt_q <= '0;
    end else if (fast_start && bit_take_o) begin
      fast_cnt_q <= fast_cnt_q + 1'b1;  // Saturates at FastStartBits
    end
  end

  // Slow interval already applies after the last fast bit
  assign reload = (fast_start && !fast_last) ? '0
                                             : (CntW'(1) << rate_sync) - CntW'(1);

  assign pulse = en_sync && (cnt_q == '0);

  always_ff @(posedge clk_dev_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (pulse) begin
      cnt_q <= reload;
    end else if (en_sync && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;            // Holds while disabled
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bit strobe and output register
  //////////////////////////////////////////////////////////////////////
  assign bit_take_o = pulse && bit_avail_i;   // Empty pulse is lost

  always_ff @(posedge clk_dev_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_bit_valid_o <= 1'b0;
      dev_bit_o       <= 1'b0;
    end else begin
      dev_bit_valid_o <= bit_take_o;
      dev_bit_o       <= bit_take_o && bit_data_i;   // Low between strobes
    end
  end

endmodule : rate_pacer

`default_nettype wire

//--- src/dev_entropy.sv
/*
 * Device entropy delivery, top level
 * Source words in by req/ack, paced single bits out
 */
`timescale 1ns/10ps
`default_nettype none

module dev_entropy (
  input  logic                              clk_dev_i,
  input  logic                              rst_ni,
  input  logic                              dev_en_i,
  input  logic [dev_entropy_pkg::RateW-1:0] dev_rate_i,
  input  logic                              src_req_i,
  input  logic [dev_entropy_pkg::WordW-1:0] src_data_i,
  output logic                              src_ack_o,
  output logic                              dev_bit_o,
  output logic                              dev_bit_valid_o
);

  import dev_entropy_pkg::*;

  logic             word_valid;      // Receiver to packer
  logic [WordW-1:0] word_data;
  logic             word_ready;
  logic             bit_avail;       // Packer to pacer
  logic             bit_data;
  logic             bit_take;

  entropy_word_rx u_word_rx (
    .clk_dev_i    (clk_dev_i),
    .rst_ni       (rst_ni),
    .src_req_i    (src_req_i),
    .src_data_i   (src_data_i),
    .src_ack_o    (src_ack_o),
    .word_valid_o (word_valid),
    .word_data_o  (word_data),
    .word_ready_i (word_ready)
  );

  bit_packer u_packer (
    .clk_dev_i    (clk_dev_i),
    .rst_ni       (rst_ni),
    .word_valid_i (word_valid),
    .word_data_i  (word_data),
    .word_ready_o (word_ready),
    .bit_avail_o  (bit_avail),
    .bit_data_o   (bit_data),
    .bit_take_i   (bit_take)
  );

  rate_pacer u_pacer (
    .clk_dev_i       (clk_dev_i),
    .rst_ni          (rst_ni),
    .dev_en_i        (dev_en_i),
    .dev_rate_i      (dev_rate_i),
    .bit_avail_i     (bit_avail),
    .bit_data_i      (bit_data),
    .bit_take_o      (bit_take),
    .dev_bit_o       (dev_bit_o),
    .dev_bit_valid_o (dev_bit_valid_o)
  );

endmodule : dev_entropy

`default_nettype wire

//--- bench/tb_dev_entropy.sv
/*
 * Device entropy testbench
 * Phase table of rates, word counts, gaps and enable pauses, with a
 * four-phase source model, bit scoreboard and output monitor
 */
`timescale 1ns/10ps
`default_nettype none

module tb_dev_entropy;

  import dev_entropy_pkg::*;

  localparam int NumPhases   = 5;
  localparam int FastBits    = 64;      // Fast-start length, own copy
  localparam int AckMinCyc   = 3;       // 2 sync + 1 register
  localparam int PauseCycles = 40;      // Enable-off window
  localparam logic [15:0] Seed = 16'd23404;

  // Phase table, one column per field      p0  p1  p2  p3  p4
  localparam int TabRate  [NumPhases] = '{ 2,  0,  5,  3,  1};  // log2 cycles/bit
  localparam int TabWords [NumPhases] = '{ 4,  3,  3,  5,  4};
  localparam int TabGap   [NumPhases] = '{ 5, 40,  0,  0,  2};  // Idle cycles before req
  localparam int TabPause [NumPhases] = '{ 0,  1,  1,  0,  1};  // Enable off mid-phase
  localparam int TabStall [NumPhases] = '{ 0,  0,  0,  1,  0};  // Back-pressure expected

  logic             clk_dev;
  logic             rst_n;
  logic             dev_en;
  logic [RateW-1:0] dev_rate;
  logic             src_req;
  logic [WordW-1:0] src_data;
  logic             src_ack;
  logic             dev_bit;
  logic             dev_bit_valid;

  bit               exp_bits[$];        // Scoreboard, LSB of each word first
  logic [15:0]      lfsr;
  logic [WordW-1:0] req_data;           // Data seen at req rise
  logic             ack_prev, req_prev;
  int cycle_cnt = 0;
  int valid_cnt, last_valid_cyc, last_valid_seg, seg_id, cur_rate;
  int en_low_cyc, stall_cyc;
  int err_data, err_hs, err_timing, err_other;

  dev_entropy dut_i (
    .clk_dev_i       (clk_dev),
    .rst_ni          (rst_n),
    .dev_en_i        (dev_en),
    .dev_rate_i      (dev_rate),
    .src_req_i       (src_req),
    .src_data_i      (src_data),
    .src_ack_o       (src_ack),
    .dev_bit_o       (dev_bit),
    .dev_bit_valid_o (dev_bit_valid)
  );

  initial begin
    clk_dev = 1'b0;
    forever #50 clk_dev = ~clk_dev;     // 100 ns period
  end

  always @(posedge clk_dev) cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  task automatic make_word(output logic [WordW-1:0] word);
    for (int i = 0; i < WordW; i++) begin
      lfsr    = lfsr_next(lfsr);        // One step per bit
      word[i] = lfsr[0];
    end
  endtask

  // Source model, one full four-phase exchange
  task automatic send_word(input logic [WordW-1:0] word, input int gap);
    int wait_cyc;
    repeat (gap) @(posedge clk_dev);
    @(posedge clk_dev);
    src_data <= word;
    src_req  <= 1'b1;
    wait_cyc = 0;
    @(negedge clk_dev);
    while (!src_ack) begin
      wait_cyc++;
      @(negedge clk_dev);
    end
    for (int i = 0; i < WordW; i++) exp_bits.push_back(word[i]);  // Accepted
    assert (wait_cyc >= AckMinCyc) else begin
      err_timing++;
      $display("ERROR: src_ack_o answered after only %0d cycles", wait_cyc);
    end
    if (wait_cyc > AckMinCyc) stall_cyc += wait_cyc - AckMinCyc;
    @(posedge clk_dev);
    src_req  <= 1'b0;
    src_data <= ~word;                  // Phase 3, data free to change
    @(negedge clk_dev);
    while (src_ack) @(negedge clk_dev);  // Phase 4 done
  endtask

  task automatic pause_enable(input int cycles);
    @(posedge clk_dev);
    dev_en <= 1'b0;
    seg_id++;                           // Spacing restarts
    repeat (cycles) @(posedge clk_dev);
    dev_en <= 1'b1;
    seg_id++;
  endtask

  // Only with the packer drained and the enable low
  task automatic change_rate(input int rate);
    @(posedge clk_dev);
    dev_en <= 1'b0;
    seg_id++;
    repeat (4) @(posedge clk_dev);
    dev_rate <= RateW'(rate);
    cur_rate = rate;
    repeat (4) @(posedge clk_dev);
    dev_en <= 1'b1;
    seg_id++;
  endtask

  task automatic run_phase(input int p);
    logic [WordW-1:0] word;
    int drain_cyc;
    stall_cyc = 0;
    if (p > 0) change_rate(TabRate[p]);
    for (int w = 0; w < TabWords[p]; w++) begin
      if (TabPause[p] != 0 && w == TabWords[p] / 2) pause_enable(PauseCycles);
      make_word(word);
      send_word(word, TabGap[p]);
    end
    drain_cyc = (exp_bits.size() + 8) << TabRate[p];   // One pulse per queued bit
    while (exp_bits.size() != 0 && drain_cyc > 0) begin  // Drain
      drain_cyc--;
      @(negedge clk_dev);
    end
    if (TabStall[p] != 0) begin
      assert (stall_cyc > 0) else begin
        err_other++;
        $display("ERROR: phase %0d never saw src_ack_o held back", p);
      end
    end
    $display("Phase %0d: rate %0d, %0d words, %0d stall cycles",
             p, TabRate[p], TabWords[p], stall_cyc);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  task automatic check_idle(input string where);
    assert (!src_ack) else begin
      err_other++;
      $display("FAIL src_ack_o %s: got %h expected %h", where, src_ack, 1'b0);
    end
    assert (!dev_bit_valid) else begin
      err_other++;
      $display("FAIL dev_bit_valid_o %s: got %h expected %h", where, dev_bit_valid, 1'b0);
    end
    assert (!dev_bit) else begin
      err_other++;
      $display("FAIL dev_bit_o %s: got %h expected %h", where, dev_bit, 1'b0);
    end
  endtask

  task automatic check_bit();
    bit expected;
    int gap;
    gap = cycle_cnt - last_valid_cyc;
    assert (exp_bits.size() != 0) else begin
      err_data++;
      $display("ERROR: output bit at cycle %0d with no word queued", cycle_cnt);
    end
    if (exp_bits.size() != 0) begin
      expected = exp_bits.pop_front();
      assert (dev_bit == expected) else begin
        err_data++;
        $display("FAIL dev_bit_o: got %h expected %h at bit %0d", dev_bit, expected, valid_cnt);
      end
    end
    // Inside one word the fast start pulses every cycle
    if (valid_cnt > 0 && valid_cnt < FastBits && last_valid_seg == seg_id
        && valid_cnt % WordW != 0) begin
      assert (gap == 1) else begin
        err_timing++;
        $display("ERROR: fast-start bit %0d came %0d cycles after the one before",
                 valid_cnt, gap);
      end
    end else if (valid_cnt >= FastBits && last_valid_seg == seg_id) begin
      assert (gap % (1 << cur_rate) == 0) else begin
        err_timing++;
        $display("FAIL valid spacing: got %h expected a multiple of %h", gap, 1 << cur_rate);
      end
    end
    last_valid_cyc = cycle_cnt;
    last_valid_seg = seg_id;
    valid_cnt++;
  endtask

  // Output monitor and handshake rules, sampled mid-cycle
  always @(negedge clk_dev) begin
    if (rst_n) begin
      if (src_ack && !ack_prev) begin
        assert (src_req) else begin
          err_hs++;
          $display("ERROR: src_ack_o rose with src_req_i low at cycle %0d", cycle_cnt);
        end
      end
      if (!src_ack && ack_prev) begin
        assert (!src_req) else begin
          err_hs++;
          $display("ERROR: src_ack_o fell with src_req_i high at cycle %0d", cycle_cnt);
        end
      end
      if (src_req && !req_prev) req_data = src_data;
      if (src_req && !src_ack) begin
        assert (src_data == req_data) else begin
          err_hs++;
          $display("FAIL src_data_i: got %h expected %h", src_data, req_data);
        end
      end
      ack_prev = src_ack;
      req_prev = src_req;
      if (!dev_en) begin                // Gating after sync delay
        if (en_low_cyc >= 3) begin
          assert (!dev_bit_valid) else begin
            err_timing++;
            $display("ERROR: bit delivered %0d cycles into enable off", en_low_cyc);
          end
        end
        en_low_cyc++;
      end else begin
        en_low_cyc = 0;
      end
      if (dev_bit_valid) check_bit();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    int total;
    rst_n    = 1'b0;
    dev_en   = 1'b0;
    dev_rate = RateW'(TabRate[0]);
    src_req  = 1'b0;
    src_data = '0;
    lfsr     = Seed;
    cur_rate = TabRate[0];
    seg_id   = 0;
    last_valid_seg = -1;
    {valid_cnt, last_valid_cyc, en_low_cyc, stall_cyc} = '0;
    {err_data, err_hs, err_timing, err_other} = '0;
    {ack_prev, req_prev} = 2'b00;
    repeat (8) begin
      @(negedge clk_dev);
      check_idle("during reset");
    end
    @(posedge clk_dev);
    rst_n <= 1'b1;
    @(negedge clk_dev);
    check_idle("after reset");
    @(posedge clk_dev);
    dev_en <= 1'b1;
    for (int p = 0; p < NumPhases; p++) run_phase(p);
    repeat (64) @(posedge clk_dev);     // No stray bits at the end
    assert (exp_bits.size() == 0) else begin
      err_data++;
      $display("ERROR: %0d expected bits never came out", exp_bits.size());
    end
    total = err_data + err_hs + err_timing + err_other;
    $display("Summary: %0d bits, errors data %0d handshake %0d timing %0d other %0d",
             valid_cnt, err_data, err_hs, err_timing, err_other);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = 8 + 64 + 1000;              // Reset, tail, margin
    for (int p = 0; p < NumPhases; p++) begin
      limit += TabWords[p] * ((WordW << TabRate[p]) + TabGap[p] + 16);
      limit += TabPause[p] * PauseCycles + 20;
    end
    repeat (limit) @(posedge clk_dev);
    $display("ERROR: run did not finish within %0d cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule : tb_dev_entropy

`default_nettype wire

//--- sim.f
src/dev_entropy_pkg.sv
src/sync_2ff.sv
src/entropy_word_rx.sv
src/bit_packer.sv
src/rate_pacer.sv
src/dev_entropy.sv
bench/tb_dev_entropy.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dev_entropy testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_dev_entropy -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG_FILE"; then
  exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1
